// File: design/afu_pkg.sv
`default_nettype none

package afu_pkg;

	////////////////////////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////////////////////////

	localparam int CU_ID_W     = 4;
	localparam int ADDR_W      = 16;
	localparam int TAG_W       = 3;
	localparam int TAG_COUNT   = 8;
	localparam int CREDIT_W    = 3;
	localparam int CREDIT_MAX  = 4;
	localparam int READ_DEPTH  = 4;
	localparam int WRITE_DEPTH = 4;

	// One-bit Wishbone address selects the queue
	localparam logic QUEUE_READ  = 1'b0;
	localparam logic QUEUE_WRITE = 1'b1;

	typedef logic [CU_ID_W-1:0]  cu_id_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_class_t;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////

	// Queue entry, also the Wishbone write data
	typedef struct packed {
		cu_id_t cu_id;
		addr_t  addr;
	} cmd_line_t;

	// Wishbone classic master side
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		logic      adr;
		cmd_line_t dat;
	} wb_req_t;

	// Issued command towards the host
	typedef struct packed {
		logic       valid;
		tag_t       tag;
		cmd_class_t cmd_class;
		cu_id_t     cu_id;
		addr_t      addr;
	} cmd_out_t;

	// Host response
	typedef struct packed {
		logic    valid;
		tag_t    tag;
		credit_t credits;
	} resp_in_t;

	// Response back to the compute unit
	typedef struct packed {
		logic       valid;
		tag_t       tag;
		cmd_class_t cmd_class;
		cu_id_t     cu_id;
	} resp_out_t;

	// Per-tag record kept while a command is outstanding
	typedef struct packed {
		cmd_class_t cmd_class;
		cu_id_t     cu_id;
	} tag_rec_t;

endpackage

`default_nettype wire

// File: design/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter int DEPTH = 4
) (
	input  wire logic              clock,
	input  wire logic              rst,
	input  wire logic              push,
	input  afu_pkg::cmd_line_t     data_in,
	input  wire logic              pop,
	output afu_pkg::cmd_line_t     data_out,
	output logic                   full,
	output logic                   empty
);

	// Storage, no reset needed on payload
	afu_pkg::cmd_line_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	logic do_push;
	logic do_pop;

	// Guard against overflow and underflow
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty = (count == '0);

	// Head entry falls through
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Pointers wrap at DEPTH
	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, push and pop together leave it unchanged
	always_ff @(posedge clock) begin
		if (rst) begin
			count <= '0;
		end else if (do_push && !do_pop) begin
			count <= count + 1'b1;
		end else if (do_pop && !do_push) begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/cmd_intake.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_intake (
	input  wire logic          clock,
	input  wire logic          rst,
	input  afu_pkg::wb_req_t   wb_req,
	output logic               wb_ack,
	input  wire logic          read_pop,
	input  wire logic          write_pop,
	output afu_pkg::cmd_line_t read_head,
	output afu_pkg::cmd_line_t write_head,
	output logic               read_empty,
	output logic               write_empty
);

	logic sel_write;
	logic read_full;
	logic write_full;
	logic target_full;
	logic take;
	logic read_push;
	logic write_push;

	////////////////////////////////////////////////////////////
	// Wishbone slave
	////////////////////////////////////////////////////////////

	// Address decode
	assign sel_write   = (wb_req.adr == afu_pkg::QUEUE_WRITE);
	assign target_full = sel_write ? write_full : read_full;

	// Accept only if the target queue has room
	// We low is acked with no effect
	assign take = wb_req.cyc && wb_req.stb && !wb_ack
		&& (!wb_req.we || !target_full);

	always_ff @(posedge clock) begin
		if (rst)
			wb_ack <= 1'b0;
		else
			wb_ack <= take;
	end

	// Push in the ack cycle, master still holds dat and adr
	assign write_push = wb_ack && wb_req.we && sel_write;
	assign read_push  = wb_ack && wb_req.we && !sel_write;

	////////////////////////////////////////////////////////////
	// Command queues
	////////////////////////////////////////////////////////////

	cmd_fifo #(
		.DEPTH(afu_pkg::READ_DEPTH)
	) read_queue_inst (
		.clock    (clock),
		.rst      (rst),
		.push     (read_push),
		.data_in  (wb_req.dat),
		.pop      (read_pop),
		.data_out (read_head),
		.full     (read_full),
		.empty    (read_empty)
	);

	cmd_fifo #(
		.DEPTH(afu_pkg::WRITE_DEPTH)
	) write_queue_inst (
		.clock    (clock),
		.rst      (rst),
		.push     (write_push),
		.data_in  (wb_req.dat),
		.pop      (write_pop),
		.data_out (write_head),
		.full     (write_full),
		.empty    (write_empty)
	);

endmodule

`default_nettype wire

// File: design/cmd_issue.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_issue (
	input  wire logic           clock,
	input  wire logic           rst,
	input  afu_pkg::cmd_line_t  read_head,
	input  afu_pkg::cmd_line_t  write_head,
	input  wire logic           read_empty,
	input  wire logic           write_empty,
	output logic                read_pop,
	output logic                write_pop,
	input  wire logic           tag_free,
	input  afu_pkg::tag_t       next_tag,
	output logic                alloc,
	output afu_pkg::tag_rec_t   alloc_rec,
	input  afu_pkg::credit_t    credit_return,
	output afu_pkg::cmd_out_t   cmd_out
);

	afu_pkg::credit_t    credit_count;
	logic                can_issue;
	afu_pkg::cmd_class_t grant_class;
	afu_pkg::cmd_line_t  grant_line;

	// Registered command towards the host
	logic                issue_valid;
	afu_pkg::tag_t       issue_tag;
	afu_pkg::cmd_class_t issue_class;
	afu_pkg::cmd_line_t  issue_line;

	////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////

	// Need a credit and a free tag
	assign can_issue = (credit_count != '0) && tag_free;

	// Writes win over reads
	assign write_pop = can_issue && !write_empty;
	assign read_pop  = can_issue && write_empty && !read_empty;
	assign alloc     = write_pop || read_pop;

	assign grant_class = write_pop ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ;
	assign grant_line  = write_pop ? write_head : read_head;

	// Record kept in the tag table until the response
	assign alloc_rec.cmd_class = grant_class;
	assign alloc_rec.cu_id     = grant_line.cu_id;

	////////////////////////////////////////////////////////////
	// Credit counter
	////////////////////////////////////////////////////////////

	// One credit per issue, host returns them with responses
	always_ff @(posedge clock) begin
		if (rst)
			credit_count <= afu_pkg::credit_t'(afu_pkg::CREDIT_MAX);
		else
			credit_count <= credit_count - afu_pkg::credit_t'(alloc) + credit_return;
	end

	// Output register
	always_ff @(posedge clock) begin
		if (rst)
			issue_valid <= 1'b0;
		else
			issue_valid <= alloc;
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			issue_tag   <= next_tag;
			issue_class <= grant_class;
			issue_line  <= grant_line;
		end
	end

	assign cmd_out.valid     = issue_valid;
	assign cmd_out.tag       = issue_tag;
	assign cmd_out.cmd_class = issue_class;
	assign cmd_out.cu_id     = issue_line.cu_id;
	assign cmd_out.addr      = issue_line.addr;

endmodule

`default_nettype wire

// File: design/tag_table.sv
`timescale 1ns/1ps
`default_nettype none

module tag_table (
	input  wire logic          clock,
	input  wire logic          rst,
	input  wire logic          alloc,
	input  afu_pkg::tag_rec_t  alloc_rec,
	output afu_pkg::tag_t      next_tag,
	output logic               tag_free,
	input  wire logic          tag_release,
	input  afu_pkg::tag_t      release_tag,
	output afu_pkg::tag_rec_t  lookup_rec
);

	// One bit per outstanding tag
	logic [afu_pkg::TAG_COUNT-1:0] busy;

	// Class and cu id of each outstanding command
	afu_pkg::tag_rec_t records [afu_pkg::TAG_COUNT];

	////////////////////////////////////////////////////////////
	// Free tag search
	////////////////////////////////////////////////////////////

	assign tag_free = !(&busy);

	// Lowest clear bit wins, scan from the top
	always_comb begin
		next_tag = '0;
		for (int i = afu_pkg::TAG_COUNT - 1; i >= 0; i--) begin
			if (!busy[i])
				next_tag = afu_pkg::tag_t'(i);
		end
	end

	// Busy bitmap
	// Alloc and release never hit the same tag in one cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (alloc && tag_free)
				busy[next_tag] <= 1'b1;
			if (tag_release)
				busy[release_tag] <= 1'b0;
		end
	end

	// Record written on allocation
	always_ff @(posedge clock) begin
		if (alloc && tag_free)
			records[next_tag] <= alloc_rec;
	end

	// Lookup for the router, combinational
	assign lookup_rec = records[release_tag];

endmodule

`default_nettype wire

// File: design/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module resp_router (
	input  wire logic          clock,
	input  wire logic          rst,
	input  afu_pkg::resp_in_t  resp_in,
	output logic               tag_release,
	output afu_pkg::tag_t      release_tag,
	input  afu_pkg::tag_rec_t  lookup_rec,
	output afu_pkg::credit_t   credit_return,
	output afu_pkg::resp_out_t resp_out
);

	// Input stage
	logic              in_valid;
	afu_pkg::tag_t     in_tag;
	afu_pkg::credit_t  in_credits;

	// Output stage
	logic              out_valid;
	afu_pkg::tag_t     out_tag;
	afu_pkg::tag_rec_t out_rec;

	////////////////////////////////////////////////////////////
	// Latch host response
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst)
			in_valid <= 1'b0;
		else
			in_valid <= resp_in.valid;
	end

	always_ff @(posedge clock) begin
		in_tag     <= resp_in.tag;
		in_credits <= resp_in.credits;
	end

	// Free the tag and hand back credits
	assign tag_release   = in_valid;
	assign release_tag   = in_tag;
	assign credit_return = in_valid ? in_credits : '0;

	// Lookup still sees the record, release lands at the edge
	always_ff @(posedge clock) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			out_tag <= in_tag;
			out_rec <= lookup_rec;
		end
	end

	assign resp_out.valid     = out_valid;
	assign resp_out.tag       = out_tag;
	assign resp_out.cmd_class = out_rec.cmd_class;
	assign resp_out.cu_id     = out_rec.cu_id;

endmodule

`default_nettype wire

// File: design/afu_control.sv
`timescale 1ns/1ps
`default_nettype none

module afu_control (
	input  wire logic          clock,
	input  wire logic          rst,
	input  afu_pkg::wb_req_t   wb_req,
	output logic               wb_ack,
	output afu_pkg::cmd_out_t  cmd_out,
	input  afu_pkg::resp_in_t  resp_in,
	output afu_pkg::resp_out_t resp_out
);

	// Queue heads and handshakes
	afu_pkg::cmd_line_t read_head;
	afu_pkg::cmd_line_t write_head;
	logic               read_empty;
	logic               write_empty;
	logic               read_pop;
	logic               write_pop;

	// Tag allocation
	logic               tag_free;
	afu_pkg::tag_t      next_tag;
	logic               alloc;
	afu_pkg::tag_rec_t  alloc_rec;

	// Response side
	logic               tag_release;
	afu_pkg::tag_t      release_tag;
	afu_pkg::tag_rec_t  lookup_rec;
	afu_pkg::credit_t   credit_return;

	////////////////////////////////////////////////////////////
	// Command path
	////////////////////////////////////////////////////////////

	cmd_intake cmd_intake_inst (
		.clock       (clock),
		.rst         (rst),
		.wb_req      (wb_req),
		.wb_ack      (wb_ack),
		.read_pop    (read_pop),
		.write_pop   (write_pop),
		.read_head   (read_head),
		.write_head  (write_head),
		.read_empty  (read_empty),
		.write_empty (write_empty)
	);

	cmd_issue cmd_issue_inst (
		.clock         (clock),
		.rst           (rst),
		.read_head     (read_head),
		.write_head    (write_head),
		.read_empty    (read_empty),
		.write_empty   (write_empty),
		.read_pop      (read_pop),
		.write_pop     (write_pop),
		.tag_free      (tag_free),
		.next_tag      (next_tag),
		.alloc         (alloc),
		.alloc_rec     (alloc_rec),
		.credit_return (credit_return),
		.cmd_out       (cmd_out)
	);

	// Tags shared by issue and response sides
	tag_table tag_table_inst (
		.clock       (clock),
		.rst         (rst),
		.alloc       (alloc),
		.alloc_rec   (alloc_rec),
		.next_tag    (next_tag),
		.tag_free    (tag_free),
		.tag_release (tag_release),
		.release_tag (release_tag),
		.lookup_rec  (lookup_rec)
	);

	resp_router resp_router_inst (
		.clock         (clock),
		.rst           (rst),
		.resp_in       (resp_in),
		.tag_release   (tag_release),
		.release_tag   (release_tag),
		.lookup_rec    (lookup_rec),
		.credit_return (credit_return),
		.resp_out      (resp_out)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic rst
);

	// Free running clock, low at time zero
	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Reset held, then released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/afu_control_checker.sv
`timescale 1ns/1ps
`default_nettype none

module afu_control_checker (
	input wire logic               clock,
	input wire logic               rst,
	input wire afu_pkg::wb_req_t   wb_req,
	input wire logic               wb_ack,
	input wire afu_pkg::cmd_out_t  cmd_out,
	input wire afu_pkg::resp_in_t  resp_in,
	input wire afu_pkg::resp_out_t resp_out
);

	// Number of failed assertions
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////
	// Wishbone
	////////////////////////////////////////////////////////////

	// Ack only inside a strobed cycle
	ack_with_stb: assert property (@(posedge clock) disable iff (rst)
		wb_ack |-> (wb_req.cyc && wb_req.stb))
		else begin
			fail_count++;
			$error("wb_ack high without cyc and stb");
		end

	////////////////////////////////////////////////////////////
	// Reset and response timing
	////////////////////////////////////////////////////////////

	// Outputs quiet one edge into reset
	quiet_in_reset: assert property (@(posedge clock)
		rst |=> (!cmd_out.valid && !resp_out.valid))
		else begin
			fail_count++;
			$error("cmd_out or resp_out valid during reset");
		end

	// Two register stages in the router
	resp_two_cycles: assert property (@(posedge clock) disable iff (rst)
		resp_in.valid |-> ##2 resp_out.valid)
		else begin
			fail_count++;
			$error("resp_out.valid missing two cycles after resp_in.valid");
		end

	resp_has_source: assert property (@(posedge clock) disable iff (rst)
		resp_out.valid |-> $past(resp_in.valid, 2))
		else begin
			fail_count++;
			$error("resp_out.valid without resp_in.valid two cycles before");
		end

endmodule

bind afu_control afu_control_checker afu_control_checker_inst (
	.clock    (clock),
	.rst      (rst),
	.wb_req   (wb_req),
	.wb_ack   (wb_ack),
	.cmd_out  (cmd_out),
	.resp_in  (resp_in),
	.resp_out (resp_out)
);

`default_nettype wire

// File: sim/afu_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module afu_control_tb;

	// About 60 commands of up to 40 cycles with margin
	localparam int          TIMEOUT_CYCLES = 4000;
	localparam int unsigned RAND_SEED      = 32'h0ec63ef6;

	logic                clock;
	logic                rst;
	afu_pkg::wb_req_t    wb_req;
	logic                wb_ack;
	afu_pkg::cmd_out_t   cmd_out;
	afu_pkg::resp_in_t   resp_in;
	afu_pkg::resp_out_t  resp_out;

	// Model of queued commands
	afu_pkg::cmd_line_t  read_model [$];
	afu_pkg::cmd_line_t  write_model [$];
	logic                pend_valid = 1'b0;
	logic                pend_adr;
	afu_pkg::cmd_line_t  pend_line;

	// Model of credits and tags
	int                            credits_model = afu_pkg::CREDIT_MAX;
	logic [afu_pkg::TAG_COUNT-1:0] busy_model = '0;
	afu_pkg::tag_rec_t             rec_model [afu_pkg::TAG_COUNT];
	afu_pkg::tag_t                 outstanding [$];

	// Host responses in flight through the router
	logic                stage1_valid = 1'b0;
	afu_pkg::tag_t       stage1_tag;
	logic                stage2_valid = 1'b0;
	afu_pkg::tag_t       stage2_tag;

	// Commands seen on cmd_out
	int                  issue_count = 0;
	int                  issue_start;

	logic                host_hold = 1'b0;
	logic                late_done;
	string               current_test = "reset";
	int                  cycle_count = 0;

	tb_clock #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (10)
	) tb_clock_inst (
		.clock (clock),
		.rst   (rst)
	);

	afu_control afu_control_inst (
		.clock    (clock),
		.rst      (rst),
		.wb_req   (wb_req),
		.wb_ack   (wb_ack),
		.cmd_out  (cmd_out),
		.resp_in  (resp_in),
		.resp_out (resp_out)
	);

	////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH test=%s %s expected=%h actual=%h", current_test, what,
			expected, actual);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_fail(input string msg);
		$display("ERROR test=%s %s", current_test, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Next issue needs a credit and takes the lowest free tag with writes first
	function automatic afu_pkg::cmd_out_t predict_cmd(input int credits,
		input logic [afu_pkg::TAG_COUNT-1:0] busy,
		input bit w_any, input afu_pkg::cmd_line_t w_head,
		input bit r_any, input afu_pkg::cmd_line_t r_head);
		afu_pkg::cmd_out_t c;
		int free_tag;
		c = '0;
		free_tag = -1;
		for (int t = 0; t < afu_pkg::TAG_COUNT; t++) begin
			if (!busy[t] && free_tag < 0)
				free_tag = t;
		end
		if (credits > 0 && free_tag >= 0 && (w_any || r_any)) begin
			c.valid = 1'b1;
			c.tag   = afu_pkg::tag_t'(free_tag);
			if (w_any) begin
				c.cmd_class = afu_pkg::CMD_WRITE;
				c.cu_id     = w_head.cu_id;
				c.addr      = w_head.addr;
			end else begin
				c.cmd_class = afu_pkg::CMD_READ;
				c.cu_id     = r_head.cu_id;
				c.addr      = r_head.addr;
			end
		end
		return c;
	endfunction

	// Response carries what was recorded for its tag
	function automatic afu_pkg::resp_out_t predict_resp(input afu_pkg::tag_t tag,
		input afu_pkg::tag_rec_t rec);
		afu_pkg::resp_out_t r;
		r.valid     = 1'b1;
		r.tag       = tag;
		r.cmd_class = rec.cmd_class;
		r.cu_id     = rec.cu_id;
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Comparison and host model on the falling edge
	////////////////////////////////////////////////////////////

	task automatic compare_cmd();
		afu_pkg::cmd_out_t  expected;
		afu_pkg::cmd_line_t w_head;
		afu_pkg::cmd_line_t r_head;
		w_head = '0;
		r_head = '0;
		if (write_model.size() != 0)
			w_head = write_model[0];
		if (read_model.size() != 0)
			r_head = read_model[0];
		expected = predict_cmd(credits_model, busy_model, write_model.size() != 0, w_head,
			read_model.size() != 0, r_head);
		if (!expected.valid) begin
			assert (cmd_out.valid === 1'b0)
				else report_fail("cmd_out.valid high with no credit, free tag or queued command");
		end else begin
			assert (cmd_out === expected)
				else report_mismatch("cmd_out", expected, cmd_out);
			if (expected.cmd_class == afu_pkg::CMD_WRITE)
				void'(write_model.pop_front());
			else
				void'(read_model.pop_front());
			credits_model--;
			busy_model[expected.tag] = 1'b1;
			rec_model[expected.tag].cmd_class = expected.cmd_class;
			rec_model[expected.tag].cu_id     = expected.cu_id;
			outstanding.push_back(expected.tag);
		end
	endtask

	task automatic compare_resp();
		afu_pkg::resp_out_t expected;
		if (stage2_valid) begin
			expected = predict_resp(stage2_tag, rec_model[stage2_tag]);
			assert (resp_out === expected)
				else report_mismatch("resp_out", expected, resp_out);
			// Tag and credit usable from the next issue decision
			busy_model[stage2_tag] = 1'b0;
			credits_model += 1;
		end else begin
			assert (resp_out.valid === 1'b0)
				else report_fail("resp_out.valid high with no response from the host");
		end
		stage2_valid = stage1_valid;
		stage2_tag   = stage1_tag;
	endtask

	// Acked line reaches the queue at the next edge
	task automatic accept_push();
		if (pend_valid) begin
			if (pend_adr == afu_pkg::QUEUE_WRITE)
				write_model.push_back(pend_line);
			else
				read_model.push_back(pend_line);
			pend_valid = 1'b0;
		end
		if (wb_ack && wb_req.we) begin
			pend_valid = 1'b1;
			pend_adr   = wb_req.adr;
			pend_line  = wb_req.dat;
		end
	endtask

	// Host answers an outstanding tag in random order
	task automatic answer_host();
		afu_pkg::resp_in_t r;
		int idx;
		r = '0;
		if (!host_hold && outstanding.size() != 0 && $urandom_range(0, 2) == 0) begin
			idx       = $urandom_range(0, outstanding.size() - 1);
			r.valid   = 1'b1;
			r.tag     = outstanding[idx];
			r.credits = afu_pkg::credit_t'(1);
			outstanding.delete(idx);
		end
		resp_in <= r;
		stage1_valid = r.valid;
		stage1_tag   = r.tag;
	endtask

	always @(negedge clock) begin
		if (!rst) begin
			if (cmd_out.valid === 1'b1)
				issue_count++;
			compare_cmd();
			compare_resp();
			accept_push();
			answer_host();
		end
	end

	// Bound protocol checker
	always @(negedge clock) begin
		assert (afu_control_inst.afu_control_checker_inst.fail_count == 0)
			else report_fail("a protocol assertion in the bound checker failed");
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout, run still busy after %0d cycles in test %s",
				TIMEOUT_CYCLES, current_test);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Wishbone classic write held through the push edge
	task automatic wb_write(input logic adr, input afu_pkg::cmd_line_t line);
		afu_pkg::wb_req_t req;
		req     = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = 1'b1;
		req.adr = adr;
		req.dat = line;
		@(negedge clock);
		wb_req <= req;
		do
			@(negedge clock);
		while (!wb_ack);
		@(negedge clock);
		wb_req <= '0;
	endtask

	task automatic send_random(input logic adr);
		afu_pkg::cmd_line_t line;
		line.cu_id = afu_pkg::cu_id_t'($urandom);
		line.addr  = afu_pkg::addr_t'($urandom);
		wb_write(adr, line);
	endtask

	task automatic begin_test(input string name);
		@(posedge clock);
		current_test = name;
	endtask

	task automatic set_hold(input logic hold);
		@(posedge clock);
		host_hold = hold;
	endtask

	// Everything issued, answered and routed
	task automatic wait_drained();
		do
			@(posedge clock);
		while (read_model.size() != 0 || write_model.size() != 0 || pend_valid
			|| outstanding.size() != 0 || stage1_valid || stage2_valid);
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		wb_req  = '0;
		resp_in = '0;
		wait (!rst);

		// Order within one queue
		begin_test("single_queue");
		repeat (10) send_random(afu_pkg::QUEUE_READ);
		repeat (10) send_random(afu_pkg::QUEUE_WRITE);
		wait_drained();

		// Both queues loaded while credits are used up
		begin_test("write_priority");
		set_hold(1'b1);
		repeat (4) send_random(afu_pkg::QUEUE_READ);
		repeat (2) begin
			send_random(afu_pkg::QUEUE_READ);
			send_random(afu_pkg::QUEUE_WRITE);
		end
		set_hold(1'b0);
		wait_drained();

		// Issue stops at the credit limit without responses
		begin_test("credit_limit");
		set_hold(1'b1);
		issue_start = issue_count;
		repeat (6) send_random(afu_pkg::QUEUE_WRITE);
		repeat (12) @(posedge clock);
		assert (issue_count - issue_start == afu_pkg::CREDIT_MAX)
			else report_mismatch("issued", afu_pkg::CREDIT_MAX, issue_count - issue_start);
		set_hold(1'b0);
		wait_drained();

		// Full write queue with no credits holds off the ack
		begin_test("full_queue");
		set_hold(1'b1);
		repeat (8) send_random(afu_pkg::QUEUE_WRITE);
		late_done = 1'b0;
		fork
			begin
				send_random(afu_pkg::QUEUE_WRITE);
				late_done = 1'b1;
			end
			begin
				repeat (20) @(posedge clock);
				assert (!late_done)
					else report_fail("write to a full queue was acked with no credit free");
				set_hold(1'b0);
			end
		join
		wait_drained();

		// Mixed traffic
		begin_test("random_mix");
		repeat (24) send_random(logic'($urandom_range(0, 1)));
		wait_drained();

		repeat (5) @(posedge clock);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
design/afu_pkg.sv
design/cmd_fifo.sv
design/cmd_intake.sv
design/cmd_issue.sv
design/tag_table.sv
design/resp_router.sv
design/afu_control.sv
sim/tb_clock.sv
sim/afu_control_checker.sv
sim/afu_control_tb.sv

// File: Bender.yml
package:
  name: afu_control

sources:
  - design/afu_pkg.sv
  - design/cmd_fifo.sv
  - design/cmd_intake.sv
  - design/cmd_issue.sv
  - design/tag_table.sv
  - design/resp_router.sv
  - design/afu_control.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/afu_control_checker.sv
      - sim/afu_control_tb.sv
